// File: dma_beat_stage.sv
// output register of one channel, beat appears one cycle after the pop
// the beat is held for a single cycle whatever ready does
`timescale 1ns/1ps
`default_nettype none

module dma_beat_stage import wr_ctx_pkg::*; (
    input  wire       clk,
    input  wire       rst,

    ctx_src_if.stage  src,
    dma_req_if.stage  dma,

    // launch markers from the controller
    input  wire       first,
    input  wire       last_in
);

    // request word is only valid while it is being popped
    logic head_load;

    assign head_load = first && src.req_rd_en;

    // --------------------
    // beat register
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dma.valid <= 1'b0;
            dma.last  <= 1'b0;
            dma.data  <= '0;
            dma.head  <= '0;
        end else if (src.pay_rd_en) begin
            dma.valid <= 1'b1;
            dma.last  <= last_in;
            dma.data  <= src.pay_dout;
            // header layout: reserved, address, byte length
            if (head_load) begin
                dma.head <= {{HEAD_PAD_W{1'b0}}, src.req_dout.addr, src.req_dout.len};
            end else begin
                dma.head <= '0;
            end
        end else begin
            // nothing launched, clear the beat
            dma.valid <= 1'b0;
            dma.last  <= 1'b0;
            dma.data  <= '0;
            dma.head  <= '0;
        end
    end

endmodule

`default_nettype wire

// File: dma_wr_ctx.sv
// context-write DMA front end, MPT and MTT channels
// FIFOs must be first-word-fall-through, opcode bits are ignored
// the DMA engine must accept every valid beat, ready only stops new reads
`timescale 1ns/1ps
`default_nettype none

module dma_wr_ctx import wr_ctx_pkg::*; #(
    parameter int CNT_W = 27
) (
    input  wire              clk,
    input  wire              rst,

    // MPT request and payload FIFOs
    output wire              dma_wr_mpt_req_rd_en,
    input  wire [REQ_W-1:0]  dma_wr_mpt_req_dout,
    input  wire              dma_wr_mpt_req_empty,
    output wire              dma_wr_mpt_rd_en,
    input  wire [DATA_W-1:0] dma_wr_mpt_dout,
    input  wire              dma_wr_mpt_empty,

    // MTT request and payload FIFOs
    output wire              dma_wr_mtt_req_rd_en,
    input  wire [REQ_W-1:0]  dma_wr_mtt_req_dout,
    input  wire              dma_wr_mtt_req_empty,
    output wire              dma_wr_mtt_rd_en,
    input  wire [DATA_W-1:0] dma_wr_mtt_dout,
    input  wire              dma_wr_mtt_empty,

    // MPT DMA write request
    output wire              dma_v2p_mpt_wr_req_valid,
    output wire              dma_v2p_mpt_wr_req_last,
    output wire [DATA_W-1:0] dma_v2p_mpt_wr_req_data,
    output wire [HEAD_W-1:0] dma_v2p_mpt_wr_req_head,
    input  wire              dma_v2p_mpt_wr_req_ready,

    // MTT DMA write request
    output wire              dma_v2p_mtt_wr_req_valid,
    output wire              dma_v2p_mtt_wr_req_last,
    output wire [DATA_W-1:0] dma_v2p_mtt_wr_req_data,
    output wire [HEAD_W-1:0] dma_v2p_mtt_wr_req_head,
    input  wire              dma_v2p_mtt_wr_req_ready
);

    ctx_src_if mpt_src ();
    ctx_src_if mtt_src ();
    dma_req_if mpt_dma ();
    dma_req_if mtt_dma ();

    logic mpt_first;
    logic mpt_last;
    logic mtt_first;
    logic mtt_last;

    // --------------------
    // FIFO side wiring
    // --------------------
    assign mpt_src.req_dout  = dma_wr_mpt_req_dout;
    assign mpt_src.req_empty = dma_wr_mpt_req_empty;
    assign mpt_src.pay_dout  = dma_wr_mpt_dout;
    assign mpt_src.pay_empty = dma_wr_mpt_empty;
    assign dma_wr_mpt_req_rd_en = mpt_src.req_rd_en;
    assign dma_wr_mpt_rd_en     = mpt_src.pay_rd_en;

    assign mtt_src.req_dout  = dma_wr_mtt_req_dout;
    assign mtt_src.req_empty = dma_wr_mtt_req_empty;
    assign mtt_src.pay_dout  = dma_wr_mtt_dout;
    assign mtt_src.pay_empty = dma_wr_mtt_empty;
    assign dma_wr_mtt_req_rd_en = mtt_src.req_rd_en;
    assign dma_wr_mtt_rd_en     = mtt_src.pay_rd_en;

    // --------------------
    // DMA side wiring
    // --------------------
    assign mpt_dma.ready            = dma_v2p_mpt_wr_req_ready;
    assign dma_v2p_mpt_wr_req_valid = mpt_dma.valid;
    assign dma_v2p_mpt_wr_req_last  = mpt_dma.last;
    assign dma_v2p_mpt_wr_req_data  = mpt_dma.data;
    assign dma_v2p_mpt_wr_req_head  = mpt_dma.head;

    assign mtt_dma.ready            = dma_v2p_mtt_wr_req_ready;
    assign dma_v2p_mtt_wr_req_valid = mtt_dma.valid;
    assign dma_v2p_mtt_wr_req_last  = mtt_dma.last;
    assign dma_v2p_mtt_wr_req_data  = mtt_dma.data;
    assign dma_v2p_mtt_wr_req_head  = mtt_dma.head;

    // --------------------
    // instances
    // --------------------

    // launch decisions for both channels
    wr_ctx_ctrl #(
        .CNT_W (CNT_W)
    ) u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .mpt_src   (mpt_src.ctrl),
        .mtt_src   (mtt_src.ctrl),
        .mpt_dma   (mpt_dma.ctrl),
        .mtt_dma   (mtt_dma.ctrl),
        .mpt_first (mpt_first),
        .mpt_last  (mpt_last),
        .mtt_first (mtt_first),
        .mtt_last  (mtt_last)
    );

    dma_beat_stage u_mpt_stage (
        .clk     (clk),
        .rst     (rst),
        .src     (mpt_src.stage),
        .dma     (mpt_dma.stage),
        .first   (mpt_first),
        .last_in (mpt_last)
    );

    dma_beat_stage u_mtt_stage (
        .clk     (clk),
        .rst     (rst),
        .src     (mtt_src.stage),
        .dma     (mtt_dma.stage),
        .first   (mtt_first),
        .last_in (mtt_last)
    );

endmodule

`default_nettype wire

// File: sources.f
wr_ctx_pkg.sv
wr_ctx_if.sv
wr_ctx_ctrl.sv
dma_beat_stage.sv
dma_wr_ctx.sv
tb_dma_wr_ctx.sv

// File: tb_dma_wr_ctx.sv
// testbench for dma_wr_ctx, random traffic on both channels from seed 96
// FIFO models are queues, expected beats come from the ceiling beat rule
// the DMA side takes every valid beat, ready only throttles reads
`timescale 1ns/1ps
`default_nettype none

module tb_dma_wr_ctx import wr_ctx_pkg::*; ();

    localparam int NUM_REQ    = 60;
    localparam int FIFO_DEPTH = 16;
    localparam int TIMEOUT    = 20000;

    logic       clk;
    logic       rst;
    logic       run;
    integer     seed;
    int         cyc, beats, val_err, other_err;
    // index 0 is MPT, index 1 is MTT
    logic [1:0] req_empty, pay_empty, ready, prev_rd;
    wire  [1:0] req_rd_en, pay_rd_en, valid, last;
    req_hdr_t   req_dout [2];
    data_t      pay_dout [2];
    wire [DATA_W-1:0] out_data [2];
    wire [HEAD_W-1:0] out_head [2];
    string      ch_name [2] = '{"mpt", "mtt"};

    // FIFO contents, streams not pushed yet, expected beats
    req_hdr_t   req_q [2][$];
    req_hdr_t   req_pend [2][$];
    data_t      pay_q [2][$];
    data_t      pay_pend [2][$];
    data_t      exp_data [2][$];
    logic       exp_last [2][$];
    head_t      exp_head [2][$];

    always #5 clk = ~clk;

    dma_wr_ctx #(.CNT_W(27)) UUT (
        .clk                      (clk),
        .rst                      (rst),
        .dma_wr_mpt_req_rd_en     (req_rd_en[0]),
        .dma_wr_mpt_req_dout      (req_dout[0]),
        .dma_wr_mpt_req_empty     (req_empty[0]),
        .dma_wr_mpt_rd_en         (pay_rd_en[0]),
        .dma_wr_mpt_dout          (pay_dout[0]),
        .dma_wr_mpt_empty         (pay_empty[0]),
        .dma_wr_mtt_req_rd_en     (req_rd_en[1]),
        .dma_wr_mtt_req_dout      (req_dout[1]),
        .dma_wr_mtt_req_empty     (req_empty[1]),
        .dma_wr_mtt_rd_en         (pay_rd_en[1]),
        .dma_wr_mtt_dout          (pay_dout[1]),
        .dma_wr_mtt_empty         (pay_empty[1]),
        .dma_v2p_mpt_wr_req_valid (valid[0]),
        .dma_v2p_mpt_wr_req_last  (last[0]),
        .dma_v2p_mpt_wr_req_data  (out_data[0]),
        .dma_v2p_mpt_wr_req_head  (out_head[0]),
        .dma_v2p_mpt_wr_req_ready (ready[0]),
        .dma_v2p_mtt_wr_req_valid (valid[1]),
        .dma_v2p_mtt_wr_req_last  (last[1]),
        .dma_v2p_mtt_wr_req_data  (out_data[1]),
        .dma_v2p_mtt_wr_req_head  (out_head[1]),
        .dma_v2p_mtt_wr_req_ready (ready[1])
    );

    task automatic check_val(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] got);
        if (exp !== got) begin
            $display("error %s exp %h got %h", name, exp, got);
            val_err++;
        end
    endtask

    // --------------------
    // stimulus and model
    // --------------------
    task automatic build_stimulus(input int ch);
        req_hdr_t r;
        data_t    d;
        int       n;
        for (int i = 0; i < NUM_REQ; i++) begin
            r.opcode = 3'($random(seed));
            r.len    = 32'($unsigned($random(seed)) % 201);
            r.addr   = {32'($random(seed)), 32'($random(seed))};
            req_pend[ch].push_back(r);
            // ceil(len / 32), zero length still one beat
            n = (r.len + 31) / 32;
            if (n == 0) begin
                n = 1;
            end
            for (int b = 0; b < n; b++) begin
                for (int w = 0; w < 8; w++) begin
                    d[w*32 +: 32] = $random(seed);
                end
                pay_pend[ch].push_back(d);
                exp_data[ch].push_back(d);
                exp_last[ch].push_back(b == n - 1);
                // header only on the first beat
                exp_head[ch].push_back(b == 0 ? {32'h0, r.addr, r.len} : '0);
            end
        end
    endtask

    // FIFO models, ready pattern and output checks, all on the rising edge
    always @(posedge clk) begin : traffic
        integer rnd;
        if (run) begin
            for (int ch = 0; ch < 2; ch++) begin
                // a read on the last edge must show up now
                check_val({ch_name[ch], "_valid"}, prev_rd[ch], valid[ch]);
                if ((req_rd_en[ch] || pay_rd_en[ch]) && !ready[ch]) begin
                    $display("%s FIFO read while ready is low", ch_name[ch]);
                    other_err++;
                end
                if (valid[ch] && exp_data[ch].size() == 0) begin
                    $display("%s beat arrived with no expected beat left", ch_name[ch]);
                    other_err++;
                end else if (valid[ch]) begin
                    check_val({ch_name[ch], "_data"}, exp_data[ch].pop_front(), out_data[ch]);
                    check_val({ch_name[ch], "_last"}, exp_last[ch].pop_front(), last[ch]);
                    check_val({ch_name[ch], "_head"}, exp_head[ch].pop_front(), out_head[ch]);
                    beats++;
                end
                prev_rd[ch] = pay_rd_en[ch];
                // pops on this edge
                if (req_rd_en[ch]) begin
                    void'(req_q[ch].pop_front());
                end
                if (pay_rd_en[ch]) begin
                    void'(pay_q[ch].pop_front());
                end
                // random pushes, bounded by depth
                rnd = $random(seed);
                if (rnd[1:0] == 2'b00 && req_pend[ch].size() != 0
                    && req_q[ch].size() < FIFO_DEPTH) begin
                    req_q[ch].push_back(req_pend[ch].pop_front());
                end
                if (rnd[2] && pay_pend[ch].size() != 0 && pay_q[ch].size() < FIFO_DEPTH) begin
                    pay_q[ch].push_back(pay_pend[ch].pop_front());
                end
                // first-word-fall-through view
                req_empty[ch] <= (req_q[ch].size() == 0);
                pay_empty[ch] <= (pay_q[ch].size() == 0);
                req_dout[ch]  <= (req_q[ch].size() != 0) ? req_q[ch][0] : '0;
                pay_dout[ch]  <= (pay_q[ch].size() != 0) ? pay_q[ch][0] : '0;
                // phase 0 stalls both, phase 1 only mpt, phase 2 only mtt
                if ((cyc / 100) % 3 == 0 || (cyc / 100) % 3 == ch + 1) begin
                    ready[ch] <= rnd[3];
                end else begin
                    ready[ch] <= 1'b1;
                end
            end
            cyc++;
        end
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin : main
        int wait_cnt;
        seed      = 96;
        clk       = 1'b0;
        rst       = 1'b1;
        run       = 1'b0;
        // FIFOs look full of work and ready is high, only reset holds reads off
        ready     = 2'b11;
        req_empty = 2'b00;
        pay_empty = 2'b00;
        prev_rd   = 2'b00;
        req_dout  = '{default: '0};
        pay_dout  = '{default: '0};
        cyc       = 0;
        beats     = 0;
        val_err   = 0;
        other_err = 0;
        build_stimulus(0);
        build_stimulus(1);
        repeat (3) @(posedge clk);
        // outputs while still in reset
        for (int ch = 0; ch < 2; ch++) begin
            check_val({ch_name[ch], "_req_rd_en"}, '0, req_rd_en[ch]);
            check_val({ch_name[ch], "_rd_en"}, '0, pay_rd_en[ch]);
            check_val({ch_name[ch], "_valid"}, '0, valid[ch]);
            check_val({ch_name[ch], "_last"}, '0, last[ch]);
            check_val({ch_name[ch], "_data"}, '0, out_data[ch]);
            check_val({ch_name[ch], "_head"}, '0, out_head[ch]);
        end
        // real FIFO state from here on
        ready     <= 2'b00;
        req_empty <= 2'b11;
        pay_empty <= 2'b11;
        rst <= 1'b0;
        run <= 1'b1;
        // drain both expected streams
        wait_cnt = 0;
        while ((exp_data[0].size() != 0 || exp_data[1].size() != 0) && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (wait_cnt >= TIMEOUT) begin
            $display("timeout with beats still expected, mpt %0d mtt %0d",
                     exp_data[0].size(), exp_data[1].size());
            other_err++;
        end
        // catch any stray beat after the end
        repeat (3) @(posedge clk);
        $display("beats %0d value errors %0d other errors %0d", beats, val_err, other_err);
        if (val_err == 0 && other_err == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: wr_ctx_ctrl.sv
// launch control for the MPT and MTT channels
// one remaining-beat counter per channel, zero means idle
// beat count is ceil(len / 32), a zero length still moves one beat
// CNT_W must hold ceil(max len / 32) - 1
`timescale 1ns/1ps
`default_nettype none

module wr_ctx_ctrl import wr_ctx_pkg::*; #(
    parameter int CNT_W = 27
) (
    input  wire        clk,
    input  wire        rst,

    ctx_src_if.ctrl    mpt_src,
    ctx_src_if.ctrl    mtt_src,
    dma_req_if.ctrl    mpt_dma,
    dma_req_if.ctrl    mtt_dma,

    // per-launch markers for the beat stages
    output logic       mpt_first,
    output logic       mpt_last,
    output logic       mtt_first,
    output logic       mtt_last
);

    // --------------------
    // beat arithmetic
    // --------------------

    // beats minus one for a byte length, ceiling division
    function automatic logic [CNT_W-1:0] beats_m1(input logic [LEN_W-1:0] len);
        logic [LEN_W:0] sum;
        logic [LEN_W:0] beats;
        sum   = {1'b0, len} + (LEN_W+1)'(BEAT_BYTES - 1);
        beats = sum >> BEAT_SHIFT;
        // zero-length request still carries one beat
        if (beats == '0) begin
            beats = (LEN_W+1)'(1);
        end
        return CNT_W'(beats - 1'b1);
    endfunction

    // --------------------
    // MPT channel
    // --------------------
    logic [CNT_W-1:0] mpt_cnt;
    logic [CNT_W-1:0] mpt_load;
    logic             mpt_busy;
    logic             mpt_first_go;
    logic             mpt_cont_go;

    assign mpt_busy = (mpt_cnt != '0);
    assign mpt_load = beats_m1(mpt_src.req_dout.len);

    // idle: need request, payload and ready
    // no pops while in reset
    assign mpt_first_go = !rst && !mpt_busy && !mpt_src.req_empty && !mpt_src.pay_empty
                          && mpt_dma.ready;
    // busy: payload only
    assign mpt_cont_go  = mpt_busy && !mpt_src.pay_empty && mpt_dma.ready;

    assign mpt_src.req_rd_en = mpt_first_go;
    assign mpt_src.pay_rd_en = mpt_first_go || mpt_cont_go;

    // last when the launch leaves the counter at zero
    assign mpt_first = mpt_first_go;
    assign mpt_last  = (mpt_first_go && (mpt_load == '0))
                       || (mpt_cont_go && (mpt_cnt == CNT_W'(1)));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mpt_cnt <= '0;
        end else if (mpt_first_go) begin
            mpt_cnt <= mpt_load;
        end else if (mpt_cont_go) begin
            mpt_cnt <= mpt_cnt - 1'b1;
        end
    end

    // --------------------
    // MTT channel
    // --------------------
    logic [CNT_W-1:0] mtt_cnt;
    logic [CNT_W-1:0] mtt_load;
    logic             mtt_busy;
    logic             mtt_first_go;
    logic             mtt_cont_go;

    assign mtt_busy = (mtt_cnt != '0);
    assign mtt_load = beats_m1(mtt_src.req_dout.len);

    // same launch rule, independent of MPT
    assign mtt_first_go = !rst && !mtt_busy && !mtt_src.req_empty && !mtt_src.pay_empty
                          && mtt_dma.ready;
    assign mtt_cont_go  = mtt_busy && !mtt_src.pay_empty && mtt_dma.ready;

    assign mtt_src.req_rd_en = mtt_first_go;
    assign mtt_src.pay_rd_en = mtt_first_go || mtt_cont_go;

    assign mtt_first = mtt_first_go;
    assign mtt_last  = (mtt_first_go && (mtt_load == '0))
                       || (mtt_cont_go && (mtt_cnt == CNT_W'(1)));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtt_cnt <= '0;
        end else if (mtt_first_go) begin
            mtt_cnt <= mtt_load;
        end else if (mtt_cont_go) begin
            // one beat gone
            mtt_cnt <= mtt_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: wr_ctx_if.sv
// channel-side bundles of the context-write front end
// FIFOs are first-word-fall-through: dout valid while empty is low
// a DMA beat is shown for one cycle and the engine must take it
`timescale 1ns/1ps
`default_nettype none

// --------------------
// FIFO source side
// --------------------
interface ctx_src_if import wr_ctx_pkg::*; ();

    // request FIFO
    logic     req_rd_en;
    req_hdr_t req_dout;
    logic     req_empty;

    // payload FIFO
    logic     pay_rd_en;
    data_t    pay_dout;
    logic     pay_empty;

    // controller pops both FIFOs
    modport ctrl (
        output req_rd_en,
        output pay_rd_en,
        input  req_dout,
        input  req_empty,
        input  pay_dout,
        input  pay_empty
    );

    // beat stage samples what is being popped
    modport stage (
        input req_dout,
        input pay_dout,
        input req_rd_en,
        input pay_rd_en
    );

endinterface

// --------------------
// DMA request side
// --------------------
interface dma_req_if import wr_ctx_pkg::*; ();

    logic  valid;
    logic  last;
    data_t data;
    // only nonzero on the first beat
    head_t head;
    logic  ready;

    modport stage (
        output valid,
        output last,
        output data,
        output head
    );

    // ready only gates new launches
    modport ctrl (
        input ready
    );

endinterface

`default_nettype wire

// File: wr_ctx_pkg.sv
// shared widths and types for the context-write DMA front end
// request word is {opcode, len, addr} from the MSB down, opcode is not decoded
// payload beats are 32 bytes and every request starts on a beat boundary
`default_nettype none

package wr_ctx_pkg;

    // --------------------
    // field widths
    // --------------------
    localparam int OPC_W  = 3;
    localparam int LEN_W  = 32;
    localparam int ADDR_W = 64;

    // request FIFO word, 99 bits
    localparam int REQ_W  = OPC_W + LEN_W + ADDR_W;

    // payload beat and DMA header
    localparam int DATA_W = 256;
    localparam int HEAD_W = 128;

    // reserved top word of the DMA header
    localparam int HEAD_PAD_W = HEAD_W - ADDR_W - LEN_W;

    // --------------------
    // beat arithmetic
    // --------------------
    localparam int BEAT_BYTES = DATA_W / 8;
    // log2 of BEAT_BYTES
    localparam int BEAT_SHIFT = 5;

    // --------------------
    // types
    // --------------------
    typedef struct packed {
        logic [OPC_W-1:0]  opcode;
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:0] addr;
    } req_hdr_t;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [HEAD_W-1:0] head_t;

endpackage

`default_nettype wire
